// File: rtl/mouse_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I subset encodings shared by decoder, ALU and phase sequencer
// import with mouse_isa_pkg::* in the module header
//////////////////////////////////////////////////////////////////////

package mouse_isa_pkg;

  // base opcodes from instruction bits 6 to 2
  // bits 1:0 are ignored, always 2'b11 for 32-bit words
  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,  // LW only
    OP_IMM = 5'b00_100,  // no shifts
    STORE  = 5'b01_000,  // SW only
    OP     = 5'b01_100,  // no shifts
    LUI    = 5'b01_101,
    BRANCH = 5'b11_000,
    JAL    = 5'b11_011
  } opc_t;

  //////////////////////////////////////////////////////////////////////
  // funct3 codes
  //////////////////////////////////////////////////////////////////////

  // alu group (R and I type)
  localparam logic [2:0] ADD  = 3'b000;  // SUB when alt is set on OP
  localparam logic [2:0] SLT  = 3'b010;  // signed less than
  localparam logic [2:0] SLTU = 3'b011;  // unsigned less than
  localparam logic [2:0] XOR  = 3'b100;
  localparam logic [2:0] OR   = 3'b110;
  localparam logic [2:0] AND  = 3'b111;

  // branch conditions (B type)
  localparam logic [2:0] BEQ  = 3'b000;  // equal
  localparam logic [2:0] BNE  = 3'b001;  // not equal
  localparam logic [2:0] BLT  = 3'b100;  // less, signed
  localparam logic [2:0] BGE  = 3'b101;  // greater or equal, signed
  localparam logic [2:0] BLTU = 3'b110;  // less, unsigned
  localparam logic [2:0] BGEU = 3'b111;  // greater or equal, unsigned

  //////////////////////////////////////////////////////////////////////
  // decoded instruction
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    opc_t        opc;  // major opcode
    logic  [4:0] rd;   // destination register
    logic  [4:0] rs1;  // source register 1
    logic  [4:0] rs2;  // source register 2
    logic  [2:0] fn3;  // funct3
    logic        alt;  // instruction bit 30
    logic [31:0] imm;  // already sign-extended for the format
  } inst_t;

endpackage

// File: rtl/mouse_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared memory bus payloads, instruction phases and address map
// import with mouse_bus_pkg::* in the module header
//////////////////////////////////////////////////////////////////////

package mouse_bus_pkg;

  // request from core to memory, held while bus_vld & ~bus_rdy
  typedef struct packed {
    logic        wen;  // write enable
    logic [31:0] adr;  // byte address, word aligned
    logic  [3:0] ben;  // byte enables, always all set here
    logic [31:0] wdt;  // write data
  } bus_req_t;

  // response from memory, valid in the transfer cycle
  typedef struct packed {
    logic [31:0] rdt;  // read data
  } bus_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // phases, one bus transfer each
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    FETCH = 3'd0,  // instruction read at pc
    RS1   = 3'd1,  // register word rs1 read
    RS2   = 3'd2,  // register word rs2 read
    MEM   = 3'd3,  // data load or store
    WB    = 3'd4   // register word rd write
  } phase_t;

  //////////////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////////////

  localparam logic [31:0] RST_ADR = 32'h0000_0000;  // first fetch
  // x0..x31 as 32 words, register n at GPR_ADR + 4n
  localparam logic [31:0] GPR_ADR = 32'h0000_0F80;

endpackage

// File: rtl/mouse_capture.sv
//////////////////////////////////////////////////////////////////////
// enable-loaded buffer register, payload type given by parameter T
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_capture #(
  parameter type T = logic [31:0]  // payload, inst_t or a data word
)(
  input  logic clk,
  input  logic rst,
  input  logic en,  // load strobe, one per transfer
  input  T     d,
  output T     q
);

  // holds its value between transfers
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      q <= '0;
    end else if (en) begin
      q <= d;  // take the bus word on the transfer edge
    end
  end

endmodule

// File: rtl/mouse_decode.sv
//////////////////////////////////////////////////////////////////////
// instruction field splitter with per-format immediate generation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_decode import mouse_isa_pkg::*; (
  input  logic [31:0] word,  // fetched instruction
  output inst_t       inst
);

  opc_t        opc;
  logic [31:0] imm;

  // bits 1:0 dropped, undefined codes pass through as is
  assign opc = opc_t'(word[6:2]);

  //////////////////////////////////////////////////////////////////////
  // immediate select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opc)
      STORE: begin
        imm = {{20{word[31]}}, word[31:25], word[11:7]};  // S
      end
      BRANCH: begin
        // B, bit 0 always zero
        imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      end
      LUI: begin
        imm = {word[31:12], 12'd0};  // U
      end
      JAL: begin
        // J, bit 0 always zero
        imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
      end
      default: begin
        imm = {{20{word[31]}}, word[31:20]};  // I for OP_IMM and LOAD
      end
    endcase
  end

  // register indexes sit at fixed positions in every format
  assign inst = '{
    opc: opc,
    rd:  word[11:7],
    rs1: word[19:15],
    rs2: word[24:20],
    fn3: word[14:12],
    alt: word[30],   // SUB select
    imm: imm
  };

endmodule

// File: rtl/mouse_pc.sv
//////////////////////////////////////////////////////////////////////
// program counter, loaded once at the last transfer of an instruction
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_pc import mouse_bus_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,    // instruction done
  input  logic        jump,    // JAL or taken branch
  input  logic [31:0] imm,     // J or B offset
  output logic [31:0] pc,      // current instruction address
  output logic [31:0] pc_inc   // pc+4, also the JAL link value
);

  logic [31:0] pc_jmp;  // jump target

  // two separate adders
  assign pc_inc = pc + 32'd4;
  assign pc_jmp = pc + imm;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= RST_ADR;
    end else if (load) begin
      pc <= jump ? pc_jmp : pc_inc;
    end
  end

endmodule

// File: rtl/mouse_alu.sv
//////////////////////////////////////////////////////////////////////
// adder, comparator and logic unit with the branch condition
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_alu import mouse_isa_pkg::*; (
  input  inst_t       inst,
  input  logic [31:0] op1,   // rs1 word
  input  logic [31:0] op2,   // immediate, rs2 word or live rs2
  output logic [31:0] res,
  output logic        take   // branch condition for fn3
);

  logic [31:0] sum;  // op1+op2
  logic [32:0] dif;  // op1-op2, msb is the borrow
  logic        ltu;  // unsigned less
  logic        lt;   // signed less
  logic        eq;

  assign sum = op1 + op2;
  assign dif = {1'b0, op1} - {1'b0, op2};

  //////////////////////////////////////////////////////////////////////
  // comparator from the subtractor
  //////////////////////////////////////////////////////////////////////

  assign ltu = dif[32];
  // signs differ so op1 sign decides, else the difference sign
  assign lt  = (op1[31] ^ op2[31]) ? op1[31] : dif[31];
  assign eq  = (dif[31:0] == 32'd0);

  // result, fn3 only matters for the alu group
  always_comb begin
    res = sum;  // addresses, ADDI
    if ((inst.opc == OP) || (inst.opc == OP_IMM)) begin
      case (inst.fn3)
        ADD:     res = ((inst.opc == OP) && inst.alt) ? dif[31:0] : sum;
        SLT:     res = {31'd0, lt};
        SLTU:    res = {31'd0, ltu};
        XOR:     res = op1 ^ op2;
        OR:      res = op1 | op2;
        AND:     res = op1 & op2;
        default: res = sum;  // shift codes not supported
      endcase
    end
  end

  always_comb begin
    case (inst.fn3)
      BEQ:     take = eq;
      BNE:     take = ~eq;
      BLT:     take = lt;
      BGE:     take = ~lt;
      BLTU:    take = ltu;
      BGEU:    take = ~ltu;
      default: take = 1'b0;
    endcase
  end

endmodule

// File: rtl/mouse_phase_fsm.sv
//////////////////////////////////////////////////////////////////////
// phase sequencer, one bus transfer per phase
// forms every bus request and steers buffers, ALU and pc
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_phase_fsm
  import mouse_isa_pkg::*;
  import mouse_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  inst_t       inst,     // live decode in the fetch transfer, buffered after
  input  logic        bus_rdy,
  input  logic [31:0] rdt,      // live read data
  input  logic [31:0] rs1_q,
  input  logic [31:0] rs2_q,    // rs2 word, or load data after MEM
  input  logic [31:0] alu_res,
  input  logic        take,
  input  logic [31:0] pc,
  input  logic [31:0] pc_inc,
  output logic        bus_vld,
  output bus_req_t    bus_req,
  output logic        inst_en,
  output logic        rs1_en,
  output logic        rs2_en,
  output logic [31:0] alu_op2,
  output logic        pc_load,
  output logic        pc_jump
);

  phase_t phase;    // current phase
  phase_t nxt;      // phase after the transfer
  logic   trn;      // transfer this cycle
  logic   rd_zero;  // x0 destination, WB skipped

  // register word address from an index
  function automatic logic [31:0] gpr_adr(input logic [4:0] idx);
    return {GPR_ADR[31:7], idx, 2'b00};
  endfunction

  assign trn     = bus_vld & bus_rdy;
  assign rd_zero = (inst.rd == 5'd0);

  //////////////////////////////////////////////////////////////////////
  // next phase, FETCH means the instruction ends here
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt = FETCH;
    case (phase)
      FETCH: begin
        case (inst.opc)
          LUI, JAL:                        if (!rd_zero) nxt = WB;
          OP_IMM, OP, LOAD, STORE, BRANCH: nxt = RS1;
          default:                         nxt = FETCH;  // undefined, no-op
        endcase
      end
      RS1: begin
        case (inst.opc)
          OP_IMM:            if (!rd_zero) nxt = WB;
          LOAD:              nxt = MEM;
          OP, STORE, BRANCH: nxt = RS2;
          default:           nxt = FETCH;
        endcase
      end
      RS2: begin
        if (inst.opc == STORE) begin
          nxt = MEM;
        end else if ((inst.opc == OP) && !rd_zero) begin
          nxt = WB;
        end  // branch ends with the rs2 read
      end
      MEM:     if ((inst.opc == LOAD) && !rd_zero) nxt = WB;
      default: nxt = FETCH;  // WB is always last
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bus_vld <= 1'b0;
      phase   <= FETCH;
    end else begin
      bus_vld <= 1'b1;  // never idles
      if (trn) begin
        phase <= nxt;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // buffer strobes and pc control
  //////////////////////////////////////////////////////////////////////

  assign inst_en = trn & (phase == FETCH);
  assign rs1_en  = trn & (phase == RS1);
  // rs2 buffer also keeps the load data until WB
  assign rs2_en  = trn & ((phase == RS2) | ((phase == MEM) & (inst.opc == LOAD)));
  assign pc_load = trn & (nxt == FETCH);
  assign pc_jump = (inst.opc == JAL) | ((inst.opc == BRANCH) & take);

  // ALU operand 2
  always_comb begin
    if ((phase == RS2) && (inst.opc == BRANCH)) begin
      alu_op2 = rdt;  // compare against the word on the bus
    end else if (inst.opc == OP) begin
      alu_op2 = rs2_q;
    end else begin
      alu_op2 = inst.imm;  // OP_IMM result, load/store address
    end
  end

  // bus request, steady while stalled
  always_comb begin
    bus_req.wen = 1'b0;
    bus_req.adr = pc;
    bus_req.ben = 4'hf;  // word access only
    bus_req.wdt = 32'd0;
    case (phase)
      RS1: bus_req.adr = gpr_adr(inst.rs1);
      RS2: bus_req.adr = gpr_adr(inst.rs2);
      MEM: begin
        bus_req.wen = (inst.opc == STORE);
        bus_req.adr = alu_res;  // rs1+imm
        bus_req.wdt = rs2_q;    // store data
      end
      WB: begin
        bus_req.wen = 1'b1;
        bus_req.adr = gpr_adr(inst.rd);
        case (inst.opc)
          LUI:     bus_req.wdt = inst.imm;
          JAL:     bus_req.wdt = pc_inc;  // link
          LOAD:    bus_req.wdt = rs2_q;
          default: bus_req.wdt = alu_res;
        endcase
      end
      default: bus_req.adr = pc;  // instruction fetch
    endcase
  end

endmodule

// File: rtl/mouse_core.sv
//////////////////////////////////////////////////////////////////////
// processor top, registers live in memory behind the one shared bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_core
  import mouse_isa_pkg::*;
  import mouse_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  output logic     bus_vld,
  output bus_req_t bus_req,
  input  logic     bus_rdy,
  input  bus_rsp_t bus_rsp
);

  inst_t       inst_dec;  // decode of the bus word
  inst_t       inst_buf;  // buffered instruction
  inst_t       inst_cur;  // instruction seen by fsm, alu and pc
  logic [31:0] rs1_q;
  logic [31:0] rs2_q;
  logic [31:0] alu_op2;
  logic [31:0] alu_res;
  logic        take;
  logic [31:0] pc;
  logic [31:0] pc_inc;
  logic        pc_load;
  logic        pc_jump;
  logic        inst_en;
  logic        rs1_en;
  logic        rs2_en;

  mouse_decode i_decode (.word(bus_rsp.rdt), .inst(inst_dec));

  //////////////////////////////////////////////////////////////////////
  // capture buffers
  //////////////////////////////////////////////////////////////////////

  mouse_capture #(.T(inst_t)) i_inst_buf (
    .clk(clk), .rst(rst), .en(inst_en), .d(inst_dec), .q(inst_buf)
  );
  mouse_capture #(.T(logic [31:0])) i_rs1_buf (
    .clk(clk), .rst(rst), .en(rs1_en), .d(bus_rsp.rdt), .q(rs1_q)
  );
  mouse_capture #(.T(logic [31:0])) i_rs2_buf (
    .clk(clk), .rst(rst), .en(rs2_en), .d(bus_rsp.rdt), .q(rs2_q)
  );

  // live decode on the fetch transfer, so one-word instructions end there
  assign inst_cur = inst_en ? inst_dec : inst_buf;

  mouse_pc i_pc (
    .clk(clk), .rst(rst), .load(pc_load), .jump(pc_jump),
    .imm(inst_cur.imm), .pc(pc), .pc_inc(pc_inc)
  );

  mouse_alu i_alu (
    .inst(inst_cur), .op1(rs1_q), .op2(alu_op2), .res(alu_res), .take(take)
  );

  mouse_phase_fsm i_phase_fsm (
    .clk(clk), .rst(rst), .inst(inst_cur), .bus_rdy(bus_rdy),
    .rdt(bus_rsp.rdt), .rs1_q(rs1_q), .rs2_q(rs2_q), .alu_res(alu_res),
    .take(take), .pc(pc), .pc_inc(pc_inc), .bus_vld(bus_vld),
    .bus_req(bus_req), .inst_en(inst_en), .rs1_en(rs1_en), .rs2_en(rs2_en),
    .alu_op2(alu_op2), .pc_load(pc_load), .pc_jump(pc_jump)
  );

endmodule

// File: sim/mouse_assert.sv
//////////////////////////////////////////////////////////////////////
// bus protocol assertions, bound into mouse_core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_assert import mouse_bus_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     bus_vld,
  input bus_req_t bus_req,
  input logic     bus_rdy
);

  int unsigned fails = 0;  // failed assertions so far

  // request held under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    (bus_vld && !bus_rdy) |=> $stable(bus_req))
    else begin
      fails++;
      $error("bus_req changed while stalled");
    end

  // no request during reset
  assert property (@(posedge clk) rst |-> !bus_vld)
    else begin
      fails++;
      $error("bus_vld high in reset");
    end

  // x0 word never written
  assert property (@(posedge clk) disable iff (rst)
    (bus_vld && bus_rdy && bus_req.wen) |-> (bus_req.adr != GPR_ADR))
    else begin
      fails++;
      $error("write to the x0 word");
    end

endmodule

bind mouse_core mouse_assert i_mouse_assert (.*);

// File: sim/mouse_tb.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for mouse_core with a stalling memory model
// each test loads a hand-encoded program, runs to the halt loop, checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mouse_tb
  import mouse_isa_pkg::*;
  import mouse_bus_pkg::*;
;

  localparam int unsigned TESTS = 6;
  localparam int unsigned GPR_W = 992;  // word index of x0

  // raw 7-bit opcodes for the encoders
  localparam logic [6:0] OPC_OPI = 7'b0010011;
  localparam logic [6:0] OPC_LD  = 7'b0000011;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        bus_vld;
  bus_req_t    bus_req;
  logic        bus_rdy = 1'b0;
  bus_rsp_t    bus_rsp;

  logic [31:0] mem [0:1023];  // live memory, written by transfers
  logic [31:0] img [0:1023];  // program image, copied in during reset
  logic [31:0] ben_mask;      // byte enables widened to bits
  int          halt_cnt = 0;  // fetches of the halt address
  logic [31:0] halt_adr = 32'd0;
  logic        stall_en = 1'b0;
  int          prg_idx;
  int          errors = 0;
  int          checks = 0;

  mouse_core i_mouse_core (
    .clk(clk), .rst(rst), .bus_vld(bus_vld), .bus_req(bus_req),
    .bus_rdy(bus_rdy), .bus_rsp(bus_rsp)
  );

  initial begin
    forever #50 clk = ~clk;  // 100 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // memory model, read data answers combinationally
  //////////////////////////////////////////////////////////////////////

  assign bus_rsp = '{rdt: mem[bus_req.adr[11:2]]};

  assign ben_mask = {{8{bus_req.ben[3]}}, {8{bus_req.ben[2]}},
                     {8{bus_req.ben[1]}}, {8{bus_req.ben[0]}}};

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= img[i];
      end
      halt_cnt <= 0;
      bus_rdy  <= 1'b1;
    end else begin
      if (bus_vld && bus_rdy) begin
        if (bus_req.wen) begin
          // only enabled bytes change
          mem[bus_req.adr[11:2]] <= (mem[bus_req.adr[11:2]] & ~ben_mask) |
                                    (bus_req.wdt & ben_mask);
        end else if (bus_req.adr == halt_adr) begin
          halt_cnt <= halt_cnt + 1;  // halt loop fetched again
        end
      end
      bus_rdy <= stall_en ? (($urandom % 4) != 0) : 1'b1;  // about 1 in 4 stalls
    end
  end

  //////////////////////////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input int rd, input int rs1,
                                        input logic [2:0] f3, input logic [31:0] imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt, input int rd,
                                        input int rs1, input int rs2);
    return {1'b0, alt, 5'd0, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(input int rs1, input int rs2, input logic [31:0] off);
    return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                        input logic [31:0] off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input int rd, input logic [31:0] up);
    return {up[19:0], rd[4:0], 7'b0110111};  // LUI
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // branch outcome from the RV32I rules
  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      default: return a >= b;  // BGEU
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // program build, run and check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic clear_image();
    for (int i = 0; i < 1024; i++) begin
      img[i] = 32'd0;  // x0 must read zero
    end
    prg_idx = 0;
  endtask

  task automatic emit(input logic [31:0] w);
    img[prg_idx] = w;
    prg_idx++;
  endtask

  task automatic emit_halt();
    halt_adr = 32'(prg_idx * 4);
    emit(enc_j(0, 32'd0));  // jal x0,0
  endtask

  task automatic apply_reset(input bit watch);
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      if (watch) begin
        checks++;
        assert (bus_vld == 1'b0) else begin
          errors++;
          $display("FAILED bus_vld: got %h expected %h during reset", bus_vld, 1'b0);
        end
      end
    end
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_halt();
    while (halt_cnt < 2) @(posedge clk);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input int idx, input logic [31:0] exp);
    check_val($sformatf("x%0d", idx), mem[GPR_W + idx], exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    clear_image();
    emit(enc_i(OPC_OPI, 1, 0, ADD, 32'd5));
    emit_halt();
    stall_en <= 1'b0;
    apply_reset(1'b1);
    do @(negedge clk); while (!(bus_vld && bus_rdy));  // first transfer
    check_val("bus_req.adr", bus_req.adr, RST_ADR);
    check_val("bus_req.wen", {31'd0, bus_req.wen}, 32'd0);
    wait_halt();
    check_reg(1, 32'd5);
  endtask

  task automatic test_op_imm();
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x5;
    clear_image();
    emit(enc_u(1, 32'h12345));
    emit(enc_i(OPC_OPI, 2, 1, ADD, -1));
    emit(enc_i(OPC_OPI, 3, 2, SLT, 5));
    emit(enc_i(OPC_OPI, 5, 0, ADD, -7));
    emit(enc_i(OPC_OPI, 6, 5, SLT, -3));
    emit(enc_i(OPC_OPI, 7, 5, SLTU, -3));
    emit(enc_i(OPC_OPI, 8, 2, SLTU, 1));
    emit(enc_i(OPC_OPI, 9, 2, XOR, 32'h5a5));
    emit(enc_i(OPC_OPI, 10, 5, OR, 32'h0f0));
    emit(enc_i(OPC_OPI, 11, 2, AND, -256));
    emit_halt();
    stall_en <= 1'b1;
    apply_reset(1'b0);
    wait_halt();
    x1 = {20'h12345, 12'd0};  // upper immediate
    x2 = x1 + 32'hffff_ffff;
    x5 = 32'd0 - 32'd7;
    check_reg(1, x1);
    check_reg(2, x2);
    check_reg(3, {31'd0, $signed(x2) < $signed(32'd5)});
    check_reg(5, x5);
    check_reg(6, {31'd0, $signed(x5) < $signed(32'hffff_fffd)});
    check_reg(7, {31'd0, x5 < 32'hffff_fffd});
    check_reg(8, {31'd0, x2 < 32'd1});
    check_reg(9, x2 ^ 32'h0000_05a5);
    check_reg(10, x5 | 32'h0000_00f0);
    check_reg(11, x2 & 32'hffff_ff00);
  endtask

  // shared by the plain and the stalled OP run
  task automatic load_alu_prog();
    clear_image();
    emit(enc_u(1, 32'h80000));
    emit(enc_i(OPC_OPI, 1, 1, ADD, -1));  // largest positive
    emit(enc_i(OPC_OPI, 2, 0, ADD, -5));
    emit(enc_i(OPC_OPI, 3, 0, ADD, 1));
    emit(enc_r(ADD, 1'b0, 4, 1, 3));      // signed overflow
    emit(enc_r(ADD, 1'b1, 5, 2, 1));
    emit(enc_r(SLT, 1'b0, 6, 2, 1));
    emit(enc_r(SLT, 1'b0, 7, 1, 2));
    emit(enc_r(SLTU, 1'b0, 8, 2, 1));
    emit(enc_r(SLTU, 1'b0, 9, 1, 2));
    emit(enc_r(XOR, 1'b0, 10, 1, 2));
    emit(enc_r(OR, 1'b0, 11, 2, 3));
    emit(enc_r(AND, 1'b0, 12, 1, 2));
    emit(enc_r(ADD, 1'b0, 0, 1, 1));      // x0 stays zero
    emit_halt();
  endtask

  task automatic check_alu_regs();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = 32'h8000_0000 + 32'hffff_ffff;
    b = 32'd0 - 32'd5;
    c = 32'd1;
    check_reg(0, 32'd0);
    check_reg(4, a + c);
    check_reg(5, b - a);
    check_reg(6, {31'd0, $signed(b) < $signed(a)});
    check_reg(7, {31'd0, $signed(a) < $signed(b)});
    check_reg(8, {31'd0, b < a});
    check_reg(9, {31'd0, a < b});
    check_reg(10, a ^ b);
    check_reg(11, b | c);
    check_reg(12, a & b);
  endtask

  task automatic test_op(input logic stalls);
    load_alu_prog();
    stall_en <= stalls;
    apply_reset(1'b0);
    wait_halt();
    check_alu_regs();
  endtask

  task automatic test_load_store();
    logic [31:0] val;
    clear_image();
    emit(enc_i(OPC_OPI, 1, 0, ADD, 32'h400));
    emit(enc_i(OPC_OPI, 1, 1, ADD, 32'h400));  // 0x800 data base
    emit(enc_u(2, 32'hcafeb));
    emit(enc_i(OPC_OPI, 2, 2, ADD, -32'h542));
    emit(enc_s(1, 2, 32'd8));
    emit(enc_i(OPC_LD, 3, 1, 3'b010, 32'd8));
    emit(enc_i(OPC_OPI, 5, 1, ADD, 32'd16));
    emit(enc_i(OPC_LD, 6, 5, 3'b010, -8));     // negative offset, same word
    emit_halt();
    stall_en <= 1'b1;
    apply_reset(1'b0);
    wait_halt();
    val = 32'hcafe_b000 - 32'h0000_0542;
    check_val("mem[0x808]", mem[32'h808 >> 2], val);
    check_reg(3, val);
    check_reg(6, val);
  endtask

  task automatic test_branch_jal();
    logic [2:0]  bf [12] = '{BEQ, BEQ, BNE, BNE, BLT, BLT, BGE, BGE, BLTU, BLTU, BGEU, BGEU};
    int          ra [12] = '{1, 1, 1, 1, 5, 6, 6, 5, 6, 5, 5, 6};
    int          rb [12] = '{2, 6, 6, 2, 6, 5, 5, 6, 5, 6, 6, 5};
    logic [31:0] rv [32];
    logic [31:0] acc [2];
    logic [31:0] link;
    int          k;
    clear_image();
    emit(enc_i(OPC_OPI, 2, 0, ADD, 32'd3));
    emit(enc_i(OPC_OPI, 1, 1, ADD, 32'd1));   // count loops to 3
    emit(enc_b(BLT, 1, 2, -4));
    emit(enc_i(OPC_OPI, 3, 3, ADD, 32'd1));
    emit(enc_b(BNE, 3, 2, -4));
    emit(enc_i(OPC_OPI, 4, 4, ADD, 32'd1));
    emit(enc_b(BLTU, 4, 2, -4));
    emit(enc_i(OPC_OPI, 5, 0, ADD, -1));
    emit(enc_i(OPC_OPI, 6, 0, ADD, 32'd1));
    for (int i = 0; i < 32; i++) rv[i] = 32'd0;
    rv[1] = 32'd3;
    rv[2] = 32'd3;
    rv[5] = 32'hffff_ffff;
    rv[6] = 32'd1;
    acc = '{32'd0, 32'd0};
    // taken branch skips its add, not taken adds one bit
    for (int i = 0; i < 12; i++) begin
      k = 1 << (i % 6);
      emit(enc_b(bf[i], ra[i], rb[i], 32'd8));
      emit(enc_i(OPC_OPI, 10 + i / 6, 10 + i / 6, ADD, k));
      if (!branch_cond(bf[i], rv[ra[i]], rv[rb[i]])) acc[i / 6] = acc[i / 6] + k;
    end
    link = 32'(prg_idx * 4) + 32'd4;
    emit(enc_j(12, 32'd8));
    emit(enc_i(OPC_OPI, 13, 0, ADD, 32'd99));  // jumped over
    emit_halt();
    stall_en <= 1'b1;
    apply_reset(1'b0);
    wait_halt();
    check_reg(1, 32'd3);
    check_reg(3, 32'd3);
    check_reg(4, 32'd3);
    check_reg(10, acc[0]);
    check_reg(11, acc[1]);
    check_reg(12, link);
    check_reg(13, 32'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence, watchdog and report
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h1cfc75ba));
    test_reset();
    test_op_imm();
    test_op(1'b0);
    test_load_store();
    test_branch_jal();
    test_op(1'b1);  // same program under back-pressure
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             i_mouse_core.i_mouse_assert.fails);
    if ((errors == 0) && (i_mouse_core.i_mouse_assert.fails == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // tests x 200 instructions x 5 transfers x 4 stall cycles x period
  initial begin
    #(TESTS * 200 * 5 * 4 * 100);
    $display("timeout, the program never reached its halt loop");
    $display("test failed");
    $finish;
  end

endmodule

// File: flist.f
rtl/mouse_isa_pkg.sv
rtl/mouse_bus_pkg.sv
rtl/mouse_capture.sv
rtl/mouse_decode.sv
rtl/mouse_pc.sv
rtl/mouse_alu.sv
rtl/mouse_phase_fsm.sv
rtl/mouse_core.sv
sim/mouse_assert.sv
sim/mouse_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mouse_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module mouse_tb -o mouse_sim

./obj_dir/mouse_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
